// File: Makefile
# Verilator flow for the photon histogram subsystem

VERILATOR ?= verilator
TOP       ?= hist_tb
SEED      ?= 62114
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
PASS_MSG  := === PASS ===

VFLAGS = --timing --assert -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -GSEED=$(SEED) -Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
rtl/hist_cfg_pkg.sv
rtl/hist_bus_pkg.sv
rtl/hist_if.sv
rtl/acq_sequencer.sv
rtl/hist_bank_ram.sv
rtl/axil_hist_reader.sv
rtl/hist_top.sv
tb/tb_clkgen.sv
tb/hist_tb.sv

// File: rtl/acq_sequencer.sv
`default_nettype none

module acq_sequencer #(
    parameter int SAMPLES = hist_cfg_pkg::SAMPLES_DEF,
    parameter int PIXELS  = hist_cfg_pkg::PIXELS_DEF,
    parameter int ACQS    = hist_cfg_pkg::ACQS_DEF
) (
    input  logic               clk,
    input  logic               res,
    input  logic               event_valid,
    input  hist_cfg_pkg::bin_t event_bin,
    output logic               event_ready,
    hist_upd_if.seq            upd
);

    import hist_cfg_pkg::*;

    localparam int SAMP_W = (SAMPLES > 1) ? $clog2(SAMPLES) : 1;
    localparam int ACQ_W  = (ACQS > 1) ? $clog2(ACQS) : 1;

    typedef enum logic {
        COUNT,
        WAIT_SWAP
    } seq_state_t;

    seq_state_t        state_q;
    logic [SAMP_W-1:0] sample_q;
    pix_t              pix_q;
    logic [ACQ_W-1:0]  acq_q;
    bank_t             bank_q;
    logic              sample_last;
    logic              pix_last;
    logic              acq_last;
    logic              upd_hs;

    // wrap points of the nested counters
    assign sample_last = (sample_q == SAMP_W'(SAMPLES - 1));
    assign pix_last    = (pix_q == pix_t'(PIXELS - 1));
    assign acq_last    = (acq_q == ACQ_W'(ACQS - 1));

    // event goes straight through, pixel tag added from the counter
    assign upd.upd_valid  = event_valid && (state_q == COUNT);
    assign upd.bin        = event_bin;
    assign upd.pixel      = pix_q;
    assign upd.bank       = bank_q;
    assign upd.frame_last = sample_last && pix_last && acq_last;

    // stall comes only from the memory side
    assign event_ready = upd.upd_ready;

    assign upd_hs = upd.upd_valid && upd.upd_ready;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state_q  <= COUNT;
            sample_q <= '0;
            pix_q    <= '0;
            acq_q    <= '0;
            bank_q   <= 1'b0;
        end else begin
            case (state_q)
                COUNT: begin
                    if (upd_hs) begin
                        // samples of one pixel first, then next pixel
                        if (sample_last) begin
                            sample_q <= '0;
                            if (pix_last) begin
                                pix_q <= '0;
                                // one pass over all pixels is one acquisition
                                if (acq_last) begin
                                    acq_q   <= '0;
                                    state_q <= WAIT_SWAP;
                                end else begin
                                    acq_q <= acq_q + 1'b1;
                                end
                            end else begin
                                pix_q <= pix_q + 1'b1;
                            end
                        end else begin
                            sample_q <= sample_q + 1'b1;
                        end
                    end
                end
                WAIT_SWAP: begin
                    // follow the memory's bank toggle
                    if (upd.bank_swap) begin
                        bank_q  <= ~bank_q;
                        state_q <= COUNT;
                    end
                end
                default: begin
                    state_q <= COUNT;
                end
            endcase
        end
    end

    // counters stay inside the frame geometry
    assert property (@(posedge clk) disable iff (!res)
        (int'(sample_q) < SAMPLES) && (int'(pix_q) < PIXELS) && (int'(acq_q) < ACQS));

    // last event of a frame comes back as a swap two cycles later
    assert property (@(posedge clk) disable iff (!res)
        upd_hs && upd.frame_last |-> ##2 upd.bank_swap);

endmodule

`default_nettype wire

// File: rtl/axil_hist_reader.sv
`default_nettype none

module axil_hist_reader (
    input  logic                    clk,
    input  logic                    res,
    input  hist_bus_pkg::axi_addr_t s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output hist_bus_pkg::axi_data_t s_rdata,
    output hist_bus_pkg::axi_resp_t s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    hist_rd_if.rdr                  rd
);

    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    localparam int HIST_WORDS = 1 << $bits(hist_addr_t);
    localparam axi_addr_t HIST_END = HIST_BASE + axi_addr_t'(HIST_WORDS * HIST_STRIDE);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        RESP
    } rd_state_t;

    rd_state_t state_q;
    logic      ar_hs;
    logic      hit_status;
    logic      hit_hist;
    logic      sel_status_q;
    logic      sel_hist_q;
    axi_addr_t hist_off;
    axi_data_t rdata_q;
    axi_resp_t rresp_q;

    // address accepted only while idle
    assign s_arready = (state_q == IDLE);
    assign ar_hs     = s_arvalid && s_arready;

    // decode
    assign hist_off   = s_araddr - HIST_BASE;
    assign hit_status = (s_araddr == REG_STATUS);
    assign hit_hist   = (s_araddr >= HIST_BASE) && (s_araddr < HIST_END)
                        && (s_araddr[1:0] == 2'b00);

    // ram read goes out with the address handshake
    // word n maps to pixel n/16, bin n%16
    assign rd.rd_en   = ar_hs && hit_hist;
    assign rd.rd_addr = hist_addr_t'(hist_off >> $clog2(HIST_STRIDE));

    assign s_rvalid = (state_q == RESP);
    assign s_rdata  = rdata_q;
    assign s_rresp  = rresp_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state_q      <= IDLE;
            sel_status_q <= 1'b0;
            sel_hist_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ar_hs) begin
                        sel_status_q <= hit_status;
                        sel_hist_q   <= hit_hist;
                        state_q      <= FETCH;
                    end
                end
                FETCH: begin
                    state_q <= RESP;
                end
                RESP: begin
                    // hold until the host takes it
                    if (s_rready) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // response word, built once in FETCH and held through RESP
    always_ff @(posedge clk) begin
        if (state_q == FETCH) begin
            if (sel_status_q) begin
                rdata_q <= {15'd0, rd.rd_bank, rd.frame_cnt};
                rresp_q <= RESP_OKAY;
            end else if (sel_hist_q) begin
                // ram data arrived this cycle
                rdata_q <= axi_data_t'(rd.rd_data);
                rresp_q <= RESP_OKAY;
            end else begin
                // unmapped, zero data
                rdata_q <= '0;
                rresp_q <= RESP_SLVERR;
            end
        end
    end

    // stalled response keeps its payload
    assert property (@(posedge clk) disable iff (!res)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp));

endmodule

`default_nettype wire

// File: rtl/hist_bank_ram.sv
`default_nettype none

module hist_bank_ram #(
    parameter int BIN_BITS  = hist_cfg_pkg::BIN_BITS_DEF,
    parameter int PIX_BITS  = hist_cfg_pkg::PIX_BITS_DEF,
    parameter int CNT_WIDTH = hist_cfg_pkg::CNT_WIDTH_DEF
) (
    input  logic    clk,
    input  logic    res,
    hist_upd_if.mem upd,
    hist_rd_if.mem  rd,
    output logic    frame_done
);

    import hist_cfg_pkg::*;

    localparam int DEPTH = 1 << (PIX_BITS + BIN_BITS);

    typedef enum logic [1:0] {
        CLR_ALL,
        IDLE,
        CLR_BANK
    } clr_state_t;

    // two banks, one counting and one readable
    logic [CNT_WIDTH-1:0] mem_q [2][DEPTH];

    clr_state_t           clr_state_q;
    hist_addr_t           clr_addr_q;
    logic                 clr_last;
    bank_t                wr_bank_q;
    logic [15:0]          frame_cnt_q;
    logic                 upd_hs;
    logic                 swap;
    // stage 1 holds the accepted update
    logic                 s1_valid_q;
    bank_t                s1_bank_q;
    hist_addr_t           s1_addr_q;
    logic                 s1_last_q;
    // stage 2 holds the old count
    logic                 s2_valid_q;
    bank_t                s2_bank_q;
    hist_addr_t           s2_addr_q;
    logic                 s2_last_q;
    logic [CNT_WIDTH-1:0] s2_cnt_q;
    logic [CNT_WIDTH-1:0] wr_cnt;
    logic                 fwd_hit;
    logic [CNT_WIDTH-1:0] rd_data_q;

    // closed while clearing or while a frame end is still in the pipe
    assign upd.upd_ready = (clr_state_q == IDLE) && !(s1_valid_q && s1_last_q)
                           && !(s2_valid_q && s2_last_q);

    assign upd_hs = upd.upd_valid && upd.upd_ready;

    // frame end leaves stage 2 together with its write
    assign swap          = s2_valid_q && s2_last_q;
    assign frame_done    = swap;
    assign upd.bank_swap = swap;

    assign wr_cnt = s2_cnt_q + 1'b1;

    // back-to-back hit, stage 2 write lands only at this edge
    assign fwd_hit = s1_valid_q && s2_valid_q && (s1_bank_q == s2_bank_q)
                     && (s1_addr_q == s2_addr_q);

    assign clr_last = (clr_addr_q == hist_addr_t'(DEPTH - 1));

    assign rd.rd_data   = rd_data_q;
    assign rd.rd_bank   = ~wr_bank_q;
    assign rd.frame_cnt = frame_cnt_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= upd_hs;
            s2_valid_q <= s1_valid_q;
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        if (upd_hs) begin
            s1_bank_q <= upd.bank;
            s1_addr_q <= {upd.pixel, upd.bin};
            s1_last_q <= upd.frame_last;
        end
        s2_bank_q <= s1_bank_q;
        s2_addr_q <= s1_addr_q;
        s2_last_q <= s1_last_q;
        // read old count, or take the one about to be written
        s2_cnt_q  <= fwd_hit ? wr_cnt : mem_q[s1_bank_q][s1_addr_q];
    end

    // clear sequencer, bank select and frame counter
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clr_state_q <= CLR_ALL;
            clr_addr_q  <= '0;
            wr_bank_q   <= 1'b0;
            frame_cnt_q <= '0;
        end else begin
            case (clr_state_q)
                CLR_ALL, CLR_BANK: begin
                    clr_addr_q <= clr_addr_q + 1'b1;
                    if (clr_last) begin
                        clr_state_q <= IDLE;
                    end
                end
                IDLE: begin
                    // new write bank was the old read bank
                    if (swap) begin
                        clr_state_q <= CLR_BANK;
                    end
                end
                default: begin
                    clr_state_q <= IDLE;
                end
            endcase
            if (swap) begin
                wr_bank_q   <= ~wr_bank_q;
                frame_cnt_q <= frame_cnt_q + 1'b1;
            end
        end
    end

    // memory writes and the host read port
    always_ff @(posedge clk) begin
        case (clr_state_q)
            CLR_ALL: begin
                // after reset both banks start empty
                mem_q[0][clr_addr_q] <= '0;
                mem_q[1][clr_addr_q] <= '0;
            end
            CLR_BANK: begin
                mem_q[wr_bank_q][clr_addr_q] <= '0;
            end
            default: begin
                if (s2_valid_q) begin
                    mem_q[s2_bank_q][s2_addr_q] <= wr_cnt;
                end
            end
        endcase
        // host always sees the bank not being counted
        if (rd.rd_en) begin
            rd_data_q <= mem_q[~wr_bank_q][rd.rd_addr];
        end
    end

    // geometry keeps every bin below full scale
    assert property (@(posedge clk) disable iff (!res)
        s2_valid_q |-> (s2_cnt_q != '1));

    // whole clear pass after a swap runs with no update taken
    assert property (@(posedge clk) disable iff (!res)
        swap |=> !upd_hs [*DEPTH]);

    // sequencer bank view tracks the memory's write bank
    assert property (@(posedge clk) disable iff (!res)
        upd_hs |-> (upd.bank == wr_bank_q));

endmodule

`default_nettype wire

// File: rtl/hist_bus_pkg.sv
`default_nettype none

package hist_bus_pkg;

    // AXI4-Lite read channel types
    typedef logic [1:0]  axi_resp_t;
    typedef logic [11:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // register map, byte offsets
    // frame count in 15:0, readable bank in bit 16
    localparam axi_addr_t REG_STATUS = 12'h000;
    // first bin word of pixel 0
    localparam axi_addr_t HIST_BASE  = 12'h100;
    // bin words are packed one per 32-bit word
    localparam int HIST_STRIDE = 4;

endpackage

`default_nettype wire

// File: rtl/hist_cfg_pkg.sv
`default_nettype none

package hist_cfg_pkg;

    // default geometry, handed to the top level as parameters
    // time-bin code width
    localparam int BIN_BITS_DEF  = 4;
    // pixel index width
    localparam int PIX_BITS_DEF  = 2;
    // bin counter width
    localparam int CNT_WIDTH_DEF = 8;
    // samples per pixel in one acquisition
    localparam int SAMPLES_DEF   = 3;
    // acquisitions per frame
    localparam int ACQS_DEF      = 5;
    localparam int PIXELS_DEF    = 4;

    // one time-bin code per detected photon
    typedef logic [BIN_BITS_DEF-1:0] bin_t;
    typedef logic [PIX_BITS_DEF-1:0] pix_t;
    typedef logic [CNT_WIDTH_DEF-1:0] cnt_t;
    // word index inside one bank, pixel in the upper bits
    typedef logic [PIX_BITS_DEF+BIN_BITS_DEF-1:0] hist_addr_t;
    // ping-pong bank select
    typedef logic bank_t;

endpackage

`default_nettype wire

// File: rtl/hist_if.sv
`default_nettype none

// histogram update path, sequencer to bank memory
interface hist_upd_if;

    import hist_cfg_pkg::*;

    logic  upd_valid;
    logic  upd_ready;
    bank_t bank;
    pix_t  pixel;
    bin_t  bin;
    // marks the final event of a frame
    logic  frame_last;
    // memory reports the bank toggle back
    logic  bank_swap;

    modport seq (
        output upd_valid, bank, pixel, bin, frame_last,
        input  upd_ready, bank_swap
    );

    modport mem (
        input  upd_valid, bank, pixel, bin, frame_last,
        output upd_ready, bank_swap
    );

endinterface

// host read path into the finished bank
interface hist_rd_if;

    import hist_cfg_pkg::*;

    logic        rd_en;
    hist_addr_t  rd_addr;
    // valid one cycle after rd_en
    cnt_t        rd_data;
    bank_t       rd_bank;
    logic [15:0] frame_cnt;

    modport rdr (
        output rd_en, rd_addr,
        input  rd_data, rd_bank, frame_cnt
    );

    modport mem (
        input  rd_en, rd_addr,
        output rd_data, rd_bank, frame_cnt
    );

endinterface

`default_nettype wire

// File: rtl/hist_top.sv
`default_nettype none

module hist_top #(
    parameter int BIN_BITS  = hist_cfg_pkg::BIN_BITS_DEF,
    parameter int PIX_BITS  = hist_cfg_pkg::PIX_BITS_DEF,
    parameter int CNT_WIDTH = hist_cfg_pkg::CNT_WIDTH_DEF,
    parameter int SAMPLES   = hist_cfg_pkg::SAMPLES_DEF,
    parameter int PIXELS    = hist_cfg_pkg::PIXELS_DEF,
    parameter int ACQS      = hist_cfg_pkg::ACQS_DEF
) (
    input  logic                    clk,
    input  logic                    res,
    // photon event stream
    input  logic                    event_valid,
    input  hist_cfg_pkg::bin_t      event_bin,
    output logic                    event_ready,
    // AXI4-Lite read slave
    input  hist_bus_pkg::axi_addr_t s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output hist_bus_pkg::axi_data_t s_rdata,
    output hist_bus_pkg::axi_resp_t s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    // one-cycle pulse per finished frame
    output logic                    frame_done
);

    hist_upd_if upd_if ();
    hist_rd_if  rd_if ();

    // producer, tags each event with its pixel
    acq_sequencer #(
        .SAMPLES (SAMPLES),
        .PIXELS  (PIXELS),
        .ACQS    (ACQS)
    ) seq_i (
        .clk         (clk),
        .res         (res),
        .event_valid (event_valid),
        .event_bin   (event_bin),
        .event_ready (event_ready),
        .upd         (upd_if.seq)
    );

    // ping-pong histogram banks
    hist_bank_ram #(
        .BIN_BITS  (BIN_BITS),
        .PIX_BITS  (PIX_BITS),
        .CNT_WIDTH (CNT_WIDTH)
    ) ram_i (
        .clk        (clk),
        .res        (res),
        .upd        (upd_if.mem),
        .rd         (rd_if.mem),
        .frame_done (frame_done)
    );

    // host side of the finished bank
    axil_hist_reader rdr_i (
        .clk       (clk),
        .res       (res),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .rd        (rd_if.rdr)
    );

endmodule

`default_nettype wire

// File: tb/hist_tb.sv
`default_nettype none

module hist_tb #(
    parameter int SEED = 62114
);

    import hist_cfg_pkg::*;
    import hist_bus_pkg::*;

    localparam int SAMPLES      = SAMPLES_DEF;
    localparam int PIXELS       = PIXELS_DEF;
    localparam int ACQS         = ACQS_DEF;
    localparam int BINS         = 1 << BIN_BITS_DEF;
    localparam int WORDS        = PIXELS * BINS;
    localparam int FRAME_EVENTS = SAMPLES * PIXELS * ACQS;
    localparam int STALL_READS  = 16;
    // wait limits in cycles
    localparam int RES_LIMIT    = 40;
    localparam int READY_LIMIT  = 400;
    localparam int DONE_LIMIT   = 20;
    localparam int AR_LIMIT     = 20;
    localparam int R_LIMIT      = 10;
    // gap in the map, past the last bin word, misaligned, top of space
    localparam axi_addr_t BAD_ADDR [4] = '{12'h004, 12'h200, 12'h102, 12'hFFC};

    logic      clk;
    logic      res;
    logic      rst_req;
    logic      event_valid;
    bin_t      event_bin;
    logic      event_ready;
    axi_addr_t s_araddr;
    logic      s_arvalid;
    logic      s_arready;
    axi_data_t s_rdata;
    axi_resp_t s_rresp;
    logic      s_rvalid;
    logic      s_rready;
    logic      frame_done;

    integer seed;
    int     errors;
    int     test_start_errors;
    int     tests_run;
    int     tests_failed;
    // model event index inside the current frame
    int     evt_idx;
    int     exp_cnt [WORDS];
    int     prev_cnt [WORDS];
    int     got_cnt [WORDS];
    bin_t   stim_bin [FRAME_EVENTS];
    int     stim_gap [FRAME_EVENTS];
    int     stall_word [STALL_READS];
    int     stall_len [STALL_READS];

    tb_clkgen #(
        .HALF_PERIOD  (50),
        .RESET_CYCLES (16)
    ) clkgen_i (
        .rst_req (rst_req),
        .clk     (clk),
        .res     (res)
    );

    hist_top #(
        .BIN_BITS  (BIN_BITS_DEF),
        .PIX_BITS  (PIX_BITS_DEF),
        .CNT_WIDTH (CNT_WIDTH_DEF),
        .SAMPLES   (SAMPLES),
        .PIXELS    (PIXELS),
        .ACQS      (ACQS)
    ) dut_i (
        .clk         (clk),
        .res         (res),
        .event_valid (event_valid),
        .event_bin   (event_bin),
        .event_ready (event_ready),
        .s_araddr    (s_araddr),
        .s_arvalid   (s_arvalid),
        .s_arready   (s_arready),
        .s_rdata     (s_rdata),
        .s_rresp     (s_rresp),
        .s_rvalid    (s_rvalid),
        .s_rready    (s_rready),
        .frame_done  (frame_done)
    );

    task automatic note_error(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_run();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t: %s did not happen in time, stopping", $time, what);
        errors++;
        finish_run();
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     errors - test_start_errors);
        end
    endtask

    task automatic clear_model();
        int n;
        for (n = 0; n < WORDS; n++) begin
            exp_cnt[n] = 0;
        end
        evt_idx = 0;
    endtask

    // samples of one pixel in a row, pixels in turn, acquisitions repeat
    task automatic model_event(input bin_t b);
        int pix;
        pix = (evt_idx / SAMPLES) % PIXELS;
        exp_cnt[pix * BINS + int'(b)]++;
        evt_idx++;
    endtask

    task automatic plan_frame();
        int r;
        int i;
        for (i = 0; i < FRAME_EVENTS; i++) begin
            r = $random(seed);
            // repeated bins with no gap hit the forwarding path
            if (i > 0 && r[8]) begin
                stim_bin[i] = stim_bin[i-1];
            end else begin
                stim_bin[i] = bin_t'(r[3:0]);
            end
            stim_gap[i] = r[6] ? 0 : int'(r[5:4]);
        end
    endtask

    task automatic plan_stalls();
        int r;
        int i;
        for (i = 0; i < STALL_READS; i++) begin
            r = $random(seed);
            stall_word[i] = r & (WORDS - 1);
            stall_len[i]  = 1 + ((r >>> 8) & 7);
        end
    endtask

    // called and left on a rising edge
    task automatic wait_reset_release();
        int t;
        t = 0;
        @(negedge clk);
        while (!res && t < RES_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!res) begin
            abort_on_timeout("reset release");
        end else begin
            // clear pass still running right after reset
            if (event_ready || frame_done || s_rvalid || !s_arready) begin
                note_error("outputs not at their reset values");
            end
            @(posedge clk);
        end
    endtask

    task automatic send_event(input bin_t b, input int gap);
        int t;
        if (gap > 0) begin
            event_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        event_valid <= 1'b1;
        event_bin   <= b;
        t = 0;
        @(negedge clk);
        while (!event_ready && t < READY_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!event_ready) begin
            abort_on_timeout("event_ready");
        end else begin
            // taken on this edge
            @(posedge clk);
            model_event(b);
        end
    endtask

    task automatic send_events(input int first, input int last);
        int i;
        for (i = first; i <= last; i++) begin
            send_event(stim_bin[i], stim_gap[i]);
        end
        event_valid <= 1'b0;
    endtask

    // pulse two cycles after the last accept and one more edge for the swap
    task automatic wait_frame_done();
        int t;
        event_valid <= 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!frame_done && t < DONE_LIMIT);
        if (!frame_done) begin
            abort_on_timeout("frame_done");
        end else begin
            if (t != 2) begin
                note_error($sformatf("frame_done %0d cycles after last event, expected 2", t));
            end
            @(negedge clk);
            if (frame_done) begin
                note_error("frame_done longer than one cycle");
            end
            @(posedge clk);
        end
    endtask

    task automatic axi_read(input axi_addr_t addr, input int stall,
                            output axi_data_t data, output axi_resp_t resp);
        int t;
        int k;
        if (stall > 0) begin
            s_rready <= 1'b0;
        end
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        t = 0;
        @(negedge clk);
        while (!s_arready && t < AR_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!s_arready) begin
            abort_on_timeout("AR handshake");
        end else begin
            @(posedge clk);
            s_arvalid <= 1'b0;
            t = 0;
            do begin
                @(negedge clk);
                t++;
            end while (!s_rvalid && t < R_LIMIT);
            if (!s_rvalid) begin
                abort_on_timeout("read response");
            end else begin
                if (t != 2) begin
                    note_error($sformatf("s_rvalid %0d cycles after AR, expected 2", t));
                end
                if (s_arready) begin
                    note_error("s_arready high with a response pending");
                end
                data = s_rdata;
                resp = s_rresp;
                // host holds off and the response must not move
                for (k = 0; k < stall; k++) begin
                    @(negedge clk);
                    if (!s_rvalid || s_rdata != data || s_rresp != resp || s_arready) begin
                        note_error($sformatf("response at 0x%03h changed while stalled",
                                             addr));
                    end
                end
                if (stall > 0) begin
                    @(posedge clk);
                    s_rready <= 1'b1;
                end
                // R handshake
                @(posedge clk);
            end
        end
    endtask

    task automatic read_all_bins(input string tag);
        int n;
        axi_data_t d;
        axi_resp_t r;
        for (n = 0; n < WORDS; n++) begin
            axi_read(HIST_BASE + axi_addr_t'(HIST_STRIDE * n), 0, d, r);
            got_cnt[n] = int'(d);
            if (r != RESP_OKAY || d != axi_data_t'(exp_cnt[n])) begin
                note_error($sformatf("%s word %0d got %0d resp %0d, expected %0d",
                                     tag, n, d, r, exp_cnt[n]));
            end
        end
    endtask

    // readable bank starts at 1 and toggles once per frame
    task automatic check_status(input int frames);
        axi_data_t d;
        axi_resp_t r;
        axi_data_t want;
        want = axi_data_t'(frames & 16'hFFFF);
        if (frames % 2 == 0) begin
            want[16] = 1'b1;
        end
        axi_read(REG_STATUS, 0, d, r);
        if (r != RESP_OKAY || d != want) begin
            note_error($sformatf("status got 0x%08h resp %0d, expected 0x%08h", d, r, want));
        end
    endtask

    // previous frame's bank read while the next frame counts
    task automatic read_stalled();
        int k;
        axi_data_t d;
        axi_resp_t r;
        for (k = 0; k < STALL_READS; k++) begin
            axi_read(HIST_BASE + axi_addr_t'(HIST_STRIDE * stall_word[k]), stall_len[k], d, r);
            if (r != RESP_OKAY || d != axi_data_t'(prev_cnt[stall_word[k]])) begin
                note_error($sformatf("stalled read word %0d got %0d, expected %0d",
                                     stall_word[k], d, prev_cnt[stall_word[k]]));
            end
        end
    endtask

    task automatic check_pixel_totals();
        int p;
        int b;
        int sum;
        for (p = 0; p < PIXELS; p++) begin
            sum = 0;
            for (b = 0; b < BINS; b++) begin
                sum += got_cnt[p * BINS + b];
            end
            if (sum != SAMPLES * ACQS) begin
                note_error($sformatf("pixel %0d total %0d, expected %0d", p, sum,
                                     SAMPLES * ACQS));
            end
        end
    endtask

    task automatic check_decode_errors();
        int k;
        axi_data_t d;
        axi_resp_t r;
        for (k = 0; k < 4; k++) begin
            axi_read(BAD_ADDR[k], k, d, r);
            if (r != RESP_SLVERR || d != '0) begin
                note_error($sformatf("address 0x%03h got 0x%08h resp %0d, expected SLVERR",
                                     BAD_ADDR[k], d, r));
            end
        end
    endtask

    initial begin
        int partial;
        seed         = SEED;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_req      = 1'b0;
        event_valid  = 1'b0;
        event_bin    = '0;
        s_araddr     = '0;
        s_arvalid    = 1'b0;
        s_rready     = 1'b1;
        clear_model();
        wait_reset_release();

        begin_test();
        plan_frame();
        send_events(0, FRAME_EVENTS - 1);
        wait_frame_done();
        read_all_bins("frame 1");
        check_status(1);
        end_test("single frame");

        // second frame lands in the cleared bank
        begin_test();
        clear_model();
        plan_frame();
        send_events(0, FRAME_EVENTS - 1);
        wait_frame_done();
        read_all_bins("frame 2");
        check_status(2);
        end_test("ping-pong");
        prev_cnt = exp_cnt;

        begin_test();
        clear_model();
        plan_frame();
        plan_stalls();
        // event stream and stalled host reads run side by side
        fork
            send_events(0, FRAME_EVENTS / 2 - 1);
            read_stalled();
        join
        send_events(FRAME_EVENTS / 2, FRAME_EVENTS - 1);
        wait_frame_done();
        read_all_bins("frame 3");
        check_pixel_totals();
        check_status(3);
        end_test("back-pressure");

        begin_test();
        check_decode_errors();
        end_test("decode errors");

        begin_test();
        plan_frame();
        partial = 10 + ($random(seed) & 15);
        send_events(0, partial - 1);
        rst_req <= 1'b1;
        repeat (4) @(posedge clk);
        rst_req <= 1'b0;
        wait_reset_release();
        clear_model();
        plan_frame();
        send_events(0, FRAME_EVENTS - 1);
        wait_frame_done();
        read_all_bins("after reset");
        check_status(1);
        end_test("reset mid-frame");

        finish_run();
    end

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 16
) (
    // extra reset request from the test sequence
    input  logic rst_req,
    output logic clk,
    output logic res
);

    logic por_done;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // power-on reset, released right after a rising edge
    initial begin
        por_done = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        por_done <= 1'b1;
    end

    assign res = por_done && !rst_req;

endmodule

`default_nettype wire
